// ==== rtl/eth_stream_pkg.sv ====
// Stream definitions for the header parser
// Beat width and the position counter used across the stages

`default_nettype none

package eth_stream_pkg;

  // 64-bit beats, byte 0 of the frame in bits 7:0
  localparam int data_width = 64;

  // Beat position within a frame
  typedef logic [2:0] beat_idx_t;

  // Counter stops here
  // Only beats 0..2 matter for the header
  localparam beat_idx_t beat_idx_max = 3'd7;

endpackage

`default_nettype wire

// ==== rtl/eth_frame_pkg.sv ====
// Ethernet frame definitions
// Header field types, EtherType values, frame class encoding and
// the two decodings of the second header beat

`default_nettype none

package eth_frame_pkg;

  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] ethertype_t;
  typedef logic [11:0] vlan_id_t;

  // 802.1Q tag protocol id
  localparam ethertype_t tpid_vlan = 16'h8100;

  // EtherTypes that get their own class
  localparam ethertype_t etype_ipv4 = 16'h0800;
  localparam ethertype_t etype_ipv6 = 16'h86dd;
  localparam ethertype_t etype_arp  = 16'h0806;

  typedef enum logic [1:0] {
    class_other = 2'd0,
    class_ipv4  = 2'd1,
    class_ipv6  = 2'd2,
    class_arp   = 2'd3
  } frame_class_t;

  // ==============================
  // Beat 1, header bytes 8 to 15
  // ==============================
  // Applied to the byte-reversed beat, so byte 8 is the top byte
  // and every field reads in network order

  // No tag, EtherType sits at bytes 12..13
  typedef struct packed {
    logic [31:0] src_mac_lo;
    ethertype_t  ethertype;
    logic [15:0] payload;
  } beat1_plain_t;

  // Tag present, TPID then TCI
  typedef struct packed {
    logic [31:0] src_mac_lo;
    ethertype_t  tpid;
    logic [2:0]  pcp;
    logic        dei;
    vlan_id_t    vid;
  } beat1_vlan_t;

  typedef union packed {
    beat1_plain_t plain;
    beat1_vlan_t  vlan;
  } beat1_u;

endpackage

`default_nettype wire

// ==== rtl/eth_beat_decoder.sv ====
// Ethernet parser decode stage
// Follows the frame lifecycle beat by beat, keeps the beat index,
// spots an 802.1Q tag on beat 1 and raises the per-beat strobes

`timescale 1ns/1ps
`default_nettype none

module eth_beat_decoder (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                s_tvalid,
  input  wire logic [eth_stream_pkg::data_width-1:0] s_tdata,
  input  wire logic                                s_tlast,
  output logic                                     frame_start,
  output logic                                     header_done,
  output logic                                     frame_end,
  output logic                                     runt_end,
  output logic                                     vlan_tagged,
  output eth_stream_pkg::beat_idx_t                beat_idx
);

  import eth_stream_pkg::*;
  import eth_frame_pkg::*;

  // ==============================
  // State
  // ==============================
  logic      in_frame;
  logic      header_seen;
  logic      tag_q;
  beat_idx_t beat_cnt;

  logic [data_width-1:0] beat_net;
  beat1_u                beat1;
  logic                  on_beat1;
  logic                  on_beat2;
  logic                  tpid_match;

  // Network byte order, byte 0 on top
  assign beat_net = {<<8{s_tdata}};
  assign beat1    = beat_net;

  assign on_beat1   = (beat_cnt == beat_idx_t'(1));
  assign on_beat2   = (beat_cnt == beat_idx_t'(2));
  assign tpid_match = (beat1.vlan.tpid == tpid_vlan);

  // Live compare on beat 1, held value afterwards
  assign vlan_tagged = on_beat1 ? tpid_match : tag_q;
  assign beat_idx    = beat_cnt;

  // ==============================
  // Strobes for the current beat
  // ==============================
  assign frame_start = s_tvalid && !in_frame;
  assign frame_end   = s_tvalid && s_tlast;

  // Untagged header ends on beat 1, tagged one on beat 2
  assign header_done = s_tvalid && ((on_beat1 && !tpid_match) || (on_beat2 && tag_q));

  // Ended before the header was complete
  assign runt_end = frame_end && !header_seen && !header_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_frame    <= 1'b0;
      header_seen <= 1'b0;
      tag_q       <= 1'b0;
      beat_cnt    <= '0;
    end else if (s_tvalid) begin
      if (s_tlast) begin
        // Back to idle, next beat is a new frame
        in_frame    <= 1'b0;
        header_seen <= 1'b0;
        tag_q       <= 1'b0;
        beat_cnt    <= '0;
      end else begin
        in_frame <= 1'b1;
        // Saturating count
        if (beat_cnt != beat_idx_max) begin
          beat_cnt <= beat_cnt + 3'd1;
        end
        if (header_done) begin
          header_seen <= 1'b1;
        end
        // Tag decision made once per frame
        if (on_beat1) begin
          tag_q <= tpid_match;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/eth_field_extract.sv ====
// Ethernet parser execute stage
// Captures destination MAC, source MAC, EtherType and VLAN id
// from header beats 0..2, holding them until the next frame

`timescale 1ns/1ps
`default_nettype none

module eth_field_extract (
  input  wire logic                                  clk,
  input  wire logic                                  rst_n,
  input  wire logic                                  s_tvalid,
  input  wire logic [eth_stream_pkg::data_width-1:0] s_tdata,
  input  wire eth_stream_pkg::beat_idx_t             beat_idx,
  input  wire logic                                  vlan_tagged,
  output eth_frame_pkg::mac_addr_t                   dst_mac,
  output eth_frame_pkg::mac_addr_t                   src_mac,
  output eth_frame_pkg::ethertype_t                  ethertype,
  output logic                                       vlan_valid,
  output eth_frame_pkg::vlan_id_t                    vlan_id
);

  import eth_stream_pkg::*;
  import eth_frame_pkg::*;

  logic [data_width-1:0] beat_net;
  beat1_u                beat1;
  logic                  take_beat0;
  logic                  take_beat1;
  logic                  take_beat2;

  // ==============================
  // Beat views
  // ==============================
  // Byte-reversed so every field slice is already in network order
  assign beat_net = {<<8{s_tdata}};
  assign beat1    = beat_net;

  assign take_beat0 = s_tvalid && (beat_idx == beat_idx_t'(0));
  assign take_beat1 = s_tvalid && (beat_idx == beat_idx_t'(1));

  // Inner EtherType only exists behind a tag
  assign take_beat2 = s_tvalid && (beat_idx == beat_idx_t'(2)) && vlan_tagged;

  // ==============================
  // Tag flag
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vlan_valid <= 1'b0;
    end else if (take_beat1) begin
      vlan_valid <= vlan_tagged;
    end
  end

  // ==============================
  // Header fields
  // ==============================
  always_ff @(posedge clk) begin
    // Bytes 0..5 dst, bytes 6..7 top of src
    if (take_beat0) begin
      dst_mac        <= beat_net[63:16];
      src_mac[47:32] <= beat_net[15:0];
    end

    // Bytes 8..11 finish src, then type or TCI
    if (take_beat1) begin
      src_mac[31:0] <= beat1.plain.src_mac_lo;
      if (vlan_tagged) begin
        vlan_id <= beat1.vlan.vid;
      end else begin
        ethertype <= beat1.plain.ethertype;
        vlan_id   <= '0;
      end
    end

    // Bytes 16..17 hold the type behind the tag
    if (take_beat2) begin
      ethertype <= beat_net[63:48];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/eth_meta_result.sv ====
// Ethernet parser result stage
// Turns the decode strobes into one-cycle metadata and runt pulses
// and maps the captured EtherType to a frame class

`timescale 1ns/1ps
`default_nettype none

module eth_meta_result (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       header_done,
  input  wire logic                       runt_end,
  input  wire eth_frame_pkg::ethertype_t  ethertype,
  output logic                            meta_valid,
  output eth_frame_pkg::frame_class_t     frame_class,
  output logic                            runt
);

  import eth_frame_pkg::*;

  // ==============================
  // Pulses
  // ==============================
  // One cycle after the accepting edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta_valid <= 1'b0;
      runt       <= 1'b0;
    end else begin
      meta_valid <= header_done;
      runt       <= runt_end;
    end
  end

  // ==============================
  // Classification
  // ==============================
  // EtherType register loads on the header_done edge,
  // so the class is settled in the meta_valid cycle
  always_comb begin
    case (ethertype)
      etype_ipv4: frame_class = class_ipv4;
      etype_ipv6: frame_class = class_ipv6;
      etype_arp:  frame_class = class_arp;
      // Anything else, incl. unknown tags
      default:    frame_class = class_other;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/eth_parser_top.sv ====
// Ethernet header parser, top level
// Decode, execute and result stages for a 64-bit stream that is
// always accepted; one metadata or runt pulse per frame

`timescale 1ns/1ps
`default_nettype none

module eth_parser_top (
  input  wire logic                                  clk,
  input  wire logic                                  rst_n,
  input  wire logic                                  s_tvalid,
  input  wire logic [eth_stream_pkg::data_width-1:0] s_tdata,
  input  wire logic                                  s_tlast,
  output logic                                       meta_valid,
  output eth_frame_pkg::mac_addr_t                   dst_mac,
  output eth_frame_pkg::mac_addr_t                   src_mac,
  output eth_frame_pkg::ethertype_t                  ethertype,
  output logic                                       vlan_valid,
  output eth_frame_pkg::vlan_id_t                    vlan_id,
  output eth_frame_pkg::frame_class_t                frame_class,
  output logic                                       runt
);

  import eth_stream_pkg::*;

  // Decode to execute/result
  logic      header_done;
  logic      runt_end;
  logic      vlan_tagged;
  beat_idx_t beat_idx;

  // Start and end strobes only feed the bound checks
  eth_beat_decoder i_decoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_tvalid    (s_tvalid),
    .s_tdata     (s_tdata),
    .s_tlast     (s_tlast),
    .frame_start (),
    .header_done (header_done),
    .frame_end   (),
    .runt_end    (runt_end),
    .vlan_tagged (vlan_tagged),
    .beat_idx    (beat_idx)
  );

  eth_field_extract i_extract (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_tvalid    (s_tvalid),
    .s_tdata     (s_tdata),
    .beat_idx    (beat_idx),
    .vlan_tagged (vlan_tagged),
    .dst_mac     (dst_mac),
    .src_mac     (src_mac),
    .ethertype   (ethertype),
    .vlan_valid  (vlan_valid),
    .vlan_id     (vlan_id)
  );

  // Class reads the held EtherType
  eth_meta_result i_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .header_done (header_done),
    .runt_end    (runt_end),
    .ethertype   (ethertype),
    .meta_valid  (meta_valid),
    .frame_class (frame_class),
    .runt        (runt)
  );

endmodule

`default_nettype wire

// ==== test/eth_parser_properties.sv ====
// Ethernet parser lifecycle and metadata timing checks
// Bound into the decode stage for frame state and into the result
// stage for pulse timing; signals a stage lacks are tied off

`timescale 1ns/1ps
`default_nettype none

module eth_parser_properties (
  input wire logic                      clk,
  input wire logic                      rst_n,
  input wire logic                      in_frame,
  input wire logic                      header_seen,
  input wire eth_stream_pkg::beat_idx_t beat_idx,
  input wire logic                      frame_start,
  input wire logic                      header_done,
  input wire logic                      frame_end,
  input wire logic                      meta_valid
);

  // ==============================
  // Frame lifecycle
  // ==============================
  // Start only from idle, at beat position 0
  start_from_idle: assert property (
    @(posedge clk) disable iff (!rst_n) frame_start |-> (beat_idx == '0)
  ) else $error("frame_start raised while a frame is open");

  // Header completes inside a frame
  header_in_frame: assert property (
    @(posedge clk) disable iff (!rst_n) header_done |-> in_frame
  ) else $error("header_done raised outside a frame");

  // At most one header per frame
  header_once: assert property (
    @(posedge clk) disable iff (!rst_n) header_done |-> !header_seen
  ) else $error("header_done raised twice in one frame");

  // Open frame, or a single-beat frame at position 0
  end_in_frame: assert property (
    @(posedge clk) disable iff (!rst_n) frame_end |-> (in_frame || beat_idx == '0)
  ) else $error("frame_end raised outside a frame");

  // ==============================
  // Metadata timing
  // ==============================
  // One pulse per header, never stretched
  meta_one_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) meta_valid |=> !meta_valid
  ) else $error("meta_valid held for more than one cycle");

endmodule

// Decode stage has no metadata pulse
bind eth_beat_decoder eth_parser_properties i_decode_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .in_frame    (in_frame),
  .header_seen (header_seen),
  .beat_idx    (beat_idx),
  .frame_start (frame_start),
  .header_done (header_done),
  .frame_end   (frame_end),
  .meta_valid  (1'b0)
);

// Result stage only sees header_done, frame state held neutral
bind eth_meta_result eth_parser_properties i_result_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .in_frame    (1'b1),
  .header_seen (1'b0),
  .beat_idx    (3'd0),
  .frame_start (1'b0),
  .header_done (header_done),
  .frame_end   (1'b0),
  .meta_valid  (meta_valid)
);

`default_nettype wire

// ==== test/eth_parser_tb.sv ====
// Testbench for the Ethernet header parser
// Replays frame beats from the test data file, checks pulse timing
// per beat and every metadata or runt result against its record

`timescale 1ns/1ps
`default_nettype none

module eth_parser_tb;

  import eth_stream_pkg::*;
  import eth_frame_pkg::*;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  s_tvalid;
  logic [data_width-1:0] s_tdata;
  logic                  s_tlast;
  logic                  meta_valid;
  mac_addr_t             dst_mac;
  mac_addr_t             src_mac;
  ethertype_t            ethertype;
  logic                  vlan_valid;
  vlan_id_t              vlan_id;
  frame_class_t          frame_class;
  logic                  runt;

  // Beats in file order; event 1 marks the header beat, 2 a runt end
  logic [data_width-1:0] beat_data[$];
  logic                  beat_last[$];
  logic [1:0]            beat_event[$];
  logic                  beat_gap[$];

  // Expected results, one per frame
  logic         exp_runt[$];
  mac_addr_t    exp_dst[$];
  mac_addr_t    exp_src[$];
  ethertype_t   exp_etype[$];
  logic         exp_vv[$];
  vlan_id_t     exp_vid[$];
  frame_class_t exp_class[$];

  logic [1:0] drv_event;
  logic       meta_due = 1'b0;
  logic       runt_due = 1'b0;
  logic       loaded = 1'b0;

  integer seed = 5;
  integer fd;
  integer code;
  integer gap_mode;
  integer gap;
  integer f_last;
  integer f_event;
  integer f_vv;
  integer f_cls;
  logic [63:0]      tag;
  logic [63:0]      f_data;
  logic [47:0]      f_dst;
  logic [47:0]      f_src;
  logic [15:0]      f_etype;
  logic [11:0]      f_vid;
  logic [8*128-1:0] rest;

  always #4 clk = ~clk;

  eth_parser_top i_eth_parser_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_tvalid    (s_tvalid),
    .s_tdata     (s_tdata),
    .s_tlast     (s_tlast),
    .meta_valid  (meta_valid),
    .dst_mac     (dst_mac),
    .src_mac     (src_mac),
    .ethertype   (ethertype),
    .vlan_valid  (vlan_valid),
    .vlan_id     (vlan_id),
    .frame_class (frame_class),
    .runt        (runt)
  );

  // ==============================
  // Reporting
  // ==============================
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Run stopped at first failure");
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] expected);
    stop_run($sformatf("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                       $time, what, got, expected));
  endtask

  task automatic pop_expected();
    void'(exp_runt.pop_front());
    void'(exp_dst.pop_front());
    void'(exp_src.pop_front());
    void'(exp_etype.pop_front());
    void'(exp_vv.pop_front());
    void'(exp_vid.pop_front());
    void'(exp_class.pop_front());
  endtask

  // ==============================
  // Result checks
  // ==============================
  task automatic check_meta(input mac_addr_t dst, input mac_addr_t src,
                            input ethertype_t etype, input logic vv,
                            input vlan_id_t vid, input frame_class_t cls);
    if (exp_runt.size() == 0) begin
      stop_run("A metadata pulse arrived but no expected result was left");
    end else begin
      if (exp_runt[0]) report_mismatch("result kind (1 = runt)", 0, 1);
      if (dst !== exp_dst[0]) report_mismatch("dst_mac", dst, exp_dst[0]);
      if (src !== exp_src[0]) report_mismatch("src_mac", src, exp_src[0]);
      if (etype !== exp_etype[0]) report_mismatch("ethertype", etype, exp_etype[0]);
      if (vv !== exp_vv[0]) report_mismatch("vlan_valid", vv, exp_vv[0]);
      if (vid !== exp_vid[0]) report_mismatch("vlan_id", vid, exp_vid[0]);
      if (cls !== exp_class[0]) report_mismatch("frame_class", cls, exp_class[0]);
      pop_expected();
    end
  endtask

  task automatic check_runt(input logic flag);
    if (exp_runt.size() == 0) begin
      stop_run("A runt pulse arrived but no expected result was left");
    end else begin
      if (flag !== exp_runt[0]) report_mismatch("result kind (1 = runt)", flag, exp_runt[0]);
      pop_expected();
    end
  endtask

  // ==============================
  // Test data
  // ==============================
  task automatic load_testdata();
    fd = $fopen("test/eth_parser_testdata.txt", "r");
    if (fd == 0) begin
      stop_run("Could not open the test data file");
    end else begin
      gap_mode = 0;
      while (!$feof(fd)) begin
        tag = '0;
        code = $fscanf(fd, "%s", tag);
        if (code == 1) begin
          case (tag[7:0])
            "#": code = $fgets(rest, fd);
            "G": code = $fscanf(fd, "%d", gap_mode);
            "B": begin
              code = $fscanf(fd, "%d %d %h", f_last, f_event, f_data);
              beat_data.push_back(f_data);
              beat_last.push_back(f_last[0]);
              beat_event.push_back(f_event[1:0]);
              beat_gap.push_back(gap_mode[0]);
            end
            "M", "R": begin
              f_dst   = '0;
              f_src   = '0;
              f_etype = '0;
              f_vv    = 0;
              f_vid   = '0;
              f_cls   = 0;
              if (tag[7:0] == "M") begin
                code = $fscanf(fd, "%h %h %h %d %h %d",
                               f_dst, f_src, f_etype, f_vv, f_vid, f_cls);
              end
              exp_runt.push_back(tag[7:0] == "R");
              exp_dst.push_back(f_dst);
              exp_src.push_back(f_src);
              exp_etype.push_back(f_etype);
              exp_vv.push_back(f_vv[0]);
              exp_vid.push_back(f_vid);
              exp_class.push_back(frame_class_t'(f_cls[1:0]));
            end
            default: stop_run("The test data file holds an unknown record type");
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  // ==============================
  // Stimulus
  // ==============================
  initial begin
    rst_n     = 1'b0;
    s_tvalid  = 1'b0;
    s_tdata   = '0;
    s_tlast   = 1'b0;
    drv_event = 2'd0;
    load_testdata();
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < beat_data.size(); i++) begin
      // Idle cycles only in the gap section
      if (beat_gap[i]) begin
        gap = $random(seed) & 3;
        repeat (gap) begin
          @(posedge clk);
          s_tvalid  <= 1'b0;
          drv_event <= 2'd0;
        end
      end
      @(posedge clk);
      s_tvalid  <= 1'b1;
      s_tdata   <= beat_data[i];
      s_tlast   <= beat_last[i];
      drv_event <= beat_event[i];
    end
    @(posedge clk);
    s_tvalid  <= 1'b0;
    s_tlast   <= 1'b0;
    drv_event <= 2'd0;
    repeat (8) @(posedge clk);
    if (exp_runt.size() != 0) begin
      stop_run($sformatf("%0d expected results never arrived", exp_runt.size()));
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

  // Pulse due one cycle after the marked beat is accepted
  always @(posedge clk) begin
    meta_due <= s_tvalid && (drv_event == 2'd1);
    runt_due <= s_tvalid && (drv_event == 2'd2);
  end

  // Outputs settle after the rising edge, sample on the falling one
  always @(negedge clk) begin
    if (rst_n) begin
      if (meta_valid !== meta_due) report_mismatch("meta_valid", meta_valid, meta_due);
      if (runt !== runt_due) report_mismatch("runt", runt, runt_due);
      if (meta_valid) check_meta(dst_mac, src_mac, ethertype, vlan_valid, vlan_id, frame_class);
      if (runt) check_runt(runt);
    end
  end

  // Up to 4 cycles per beat with gaps, plus reset and drain
  initial begin
    wait (loaded);
    repeat (beat_data.size() * 4 + 200) @(posedge clk);
    stop_run("Timeout: the run did not finish in the allowed number of cycles");
  end

endmodule

`default_nettype wire

// ==== test/eth_parser_testdata.txt ====
# B tlast event(0 none, 1 header beat, 2 runt end) tdata, G gaps(0 off, 1 on)
# M dst_mac src_mac ethertype vlan_valid vlan_id class(0 other 1 ipv4 2 ipv6 3 arp), R runt
G 0
# Untagged IPv4
B 0 0 7766554433221100
B 0 1 00450008bbaa9988
B 1 0 0000000000000001
M 001122334455 66778899aabb 0800 0 000 1
# Tagged IPv6, VLAN 0x123
B 0 0 0002010000000002
B 0 0 23a1008102000000
B 0 1 000000000060dd86
B 1 0 1111111111111111
M 020000000001 020000000002 86dd 1 123 2
# ARP ending on its header beat
B 0 0 0b0affffffffffff
B 1 1 010006080f0e0d0c
M ffffffffffff 0a0b0c0d0e0f 0806 0 000 3
# Runts: end at beat 0, tagged end at beat 1
B 1 2 0706050403020100
R
B 0 0 0f0e0d0c0b0a0908
B 1 2 0500008100000000
R
G 1
B 0 0 8070605040302010
B 0 1 addeb588c0b0a090
B 1 0 0000000000000000
M 102030405060 708090a0b0c0 88b5 0 000 0
B 0 0 1b000101005e0000
B 0 0 0a0000815e4d3c21
B 1 1 00001c0000450008
M 00005e000101 001b213c4d5e 0800 1 00a 1
B 1 2 ffffffffffffffff
R

// ==== eth_parser.f ====
rtl/eth_stream_pkg.sv
rtl/eth_frame_pkg.sv
rtl/eth_beat_decoder.sv
rtl/eth_field_extract.sv
rtl/eth_meta_result.sv
rtl/eth_parser_top.sv
test/eth_parser_properties.sv
test/eth_parser_tb.sv

// ==== Bender.yml ====
package:
  name: eth_parser

sources:
  - files:
      - rtl/eth_stream_pkg.sv
      - rtl/eth_frame_pkg.sv
      - rtl/eth_beat_decoder.sv
      - rtl/eth_field_extract.sv
      - rtl/eth_meta_result.sv
      - rtl/eth_parser_top.sv
  - target: test
    files:
      - test/eth_parser_properties.sv
      - test/eth_parser_tb.sv
